//--- verilog/equihash_pkg.sv
// Shared sizes and types for the Equihash index-list checker.
// Modules refer to these by scoped name. The top level takes its
// parameter defaults from here and passes them down.
`default_nettype none

package equihash_pkg;

  // Default input word width in bytes
  parameter int unsigned DEF_DAT_BYTS = 8;

  // Default index width and indices per solution (list length is a power of two)
  parameter int unsigned DEF_SOL_BITS     = 10;
  parameter int unsigned DEF_SOL_LIST_LEN = 32;

  // Widest index the beat can carry
  parameter int unsigned MAX_SOL_BITS = 16;

  // One unpacked index, zero-extended, with solution framing
  typedef struct packed {
    logic [MAX_SOL_BITS-1:0] idx;
    logic                    first;
    logic                    last;
  } idx_beat_t;

  // Result mask with one failure bit per check
  typedef struct packed {
    logic dup_fnd;
    logic bad_idx_order;
    logic len_err;
  } verif_mask_t;

  // One input word of the compressed solution
  typedef struct packed {
    logic [DEF_DAT_BYTS*8-1:0] dat;
    logic                      eop;
  } in_beat_t;

endpackage

`default_nettype wire

//--- verilog/sol_store.sv
// Solution store for the checker input stream.
// Accepts words on valid/ready, writes the first SOL_WORDS of them into
// a RAM with a one-cycle read port and judges the length on eop.
// Input stays blocked after eop until the result block releases it.
`timescale 1ns/1ps
`default_nettype none

module sol_store #(
  parameter int DAT_BYTS     = equihash_pkg::DEF_DAT_BYTS,
  parameter int SOL_BITS     = equihash_pkg::DEF_SOL_BITS,
  parameter int SOL_LIST_LEN = equihash_pkg::DEF_SOL_LIST_LEN,
  localparam int DAT_BITS    = DAT_BYTS * 8,
  localparam int SOL_WORDS   = (SOL_BITS * SOL_LIST_LEN + DAT_BITS - 1) / DAT_BITS,
  localparam int ADDR_W      = (SOL_WORDS > 1) ? $clog2(SOL_WORDS) : 1
) (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst,
  input  wire logic                   i_valid,
  input  wire equihash_pkg::in_beat_t i_beat,
  input  wire logic                   i_release,
  input  wire logic [ADDR_W-1:0]      i_rd_addr,
  output logic                        o_ready,
  output logic [DAT_BITS-1:0]         o_rd_data,
  output logic                        o_start,
  output logic                        o_sol_end,
  output logic                        o_len_err
);

  localparam int CNT_W = $clog2(SOL_WORDS + 1);
  localparam logic [CNT_W-1:0] LAST_WORD = CNT_W'(SOL_WORDS - 1);
  localparam logic [CNT_W-1:0] FULL      = CNT_W'(SOL_WORDS);

  typedef enum logic {
    ST_ACCEPT,
    ST_WAIT
  } state_t;

  state_t              state;
  logic [CNT_W-1:0]    wr_cnt;
  logic [DAT_BITS-1:0] ram [SOL_WORDS];
  logic                xfer;
  logic                eop_xfer;

  assign xfer     = i_valid && o_ready;
  assign eop_xfer = xfer && i_beat.eop;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= ST_ACCEPT;
      o_ready   <= 1'b0;
      wr_cnt    <= '0;
      o_start   <= 1'b0;
      o_sol_end <= 1'b0;
    end else begin
      o_start   <= 1'b0;
      o_sol_end <= 1'b0;
      case (state)
        ST_ACCEPT: begin
          o_ready <= 1'b1;
          // Counter saturates once the RAM is full and later words are dropped
          if (xfer && wr_cnt != FULL) begin
            wr_cnt <= wr_cnt + 1'b1;
          end
          if (eop_xfer) begin
            o_ready   <= 1'b0;
            wr_cnt    <= '0;
            o_sol_end <= 1'b1;
            o_start   <= (wr_cnt == LAST_WORD);
            state     <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          // Held until the mask for this solution is out
          if (i_release) begin
            o_ready <= 1'b1;
            state   <= ST_ACCEPT;
          end
        end
        default: state <= ST_ACCEPT;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (xfer && wr_cnt != FULL) begin
      ram[wr_cnt[ADDR_W-1:0]] <= i_beat.dat;
    end
    // Length is right only when eop lands on the last RAM word
    if (eop_xfer) begin
      o_len_err <= (wr_cnt != LAST_WORD);
    end
    o_rd_data <= ram[i_rd_addr];
  end

endmodule

`default_nettype wire

//--- verilog/index_unpacker.sv
// Index unpacker for the stored solution words.
// Keeps two words in a window, pulls SOL_BITS at a time in stream order
// (byte 0 first, MSB first in each byte) and emits one beat per cycle.
// A cycle without a beat is spent whenever the window moves one word.
// Needs SOL_BITS no wider than one input word.
`timescale 1ns/1ps
`default_nettype none

module index_unpacker #(
  parameter int DAT_BYTS     = equihash_pkg::DEF_DAT_BYTS,
  parameter int SOL_BITS     = equihash_pkg::DEF_SOL_BITS,
  parameter int SOL_LIST_LEN = equihash_pkg::DEF_SOL_LIST_LEN,
  localparam int DAT_BITS    = DAT_BYTS * 8,
  localparam int SOL_WORDS   = (SOL_BITS * SOL_LIST_LEN + DAT_BITS - 1) / DAT_BITS,
  localparam int ADDR_W      = (SOL_WORDS > 1) ? $clog2(SOL_WORDS) : 1
) (
  input  wire logic                 i_clk,
  input  wire logic                 i_rst,
  input  wire logic                 i_start,
  input  wire logic [DAT_BITS-1:0]  i_rd_data,
  output logic [ADDR_W-1:0]         o_rd_addr,
  output logic                      o_idx_val,
  output equihash_pkg::idx_beat_t   o_idx
);

  localparam int POS_W = $clog2(2 * DAT_BITS);
  localparam int CNT_W = $clog2(SOL_LIST_LEN);
  localparam int IDX_W = equihash_pkg::MAX_SOL_BITS;
  localparam logic [ADDR_W-1:0] LAST_ADDR = ADDR_W'(SOL_WORDS - 1);
  localparam logic [POS_W-1:0]  WORD_POS  = POS_W'(DAT_BITS);
  localparam logic [POS_W-1:0]  STEP      = POS_W'(SOL_BITS);
  localparam logic [CNT_W-1:0]  LAST_IDX  = CNT_W'(SOL_LIST_LEN - 1);

  typedef enum logic [2:0] {
    U_IDLE,
    U_LOAD0,
    U_LOAD1,
    U_LOAD2,
    U_RUN
  } state_t;

  state_t                state;
  logic [DAT_BITS-1:0]   win_lo;
  logic [DAT_BITS-1:0]   win_hi;
  logic [2*DAT_BITS-1:0] win;
  logic [2*DAT_BITS-1:0] win_sh;
  logic [POS_W-1:0]      pos;
  logic [CNT_W-1:0]      idx_cnt;
  logic [ADDR_W-1:0]     next_addr;
  logic                  refill;
  logic [SOL_BITS-1:0]   cur_idx;

  // Puts byte 0 on top so the stream reads from the MSB down
  function automatic logic [DAT_BITS-1:0] byte_swap(input logic [DAT_BITS-1:0] w);
    logic [DAT_BITS-1:0] r;
    for (int b = 0; b < DAT_BYTS; b++) begin
      r[(DAT_BYTS-1-b)*8 +: 8] = w[b*8 +: 8];
    end
    return r;
  endfunction

  assign win     = {byte_swap(win_lo), byte_swap(win_hi)};
  assign win_sh  = win << pos;
  assign cur_idx = win_sh[2*DAT_BITS-1 -: SOL_BITS];
  assign refill  = (pos >= WORD_POS);
  // Reads past the last word repeat it and those bits are never used
  assign next_addr = (o_rd_addr == LAST_ADDR) ? o_rd_addr : o_rd_addr + 1'b1;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state     <= U_IDLE;
      o_rd_addr <= '0;
      pos       <= '0;
      idx_cnt   <= '0;
      o_idx_val <= 1'b0;
    end else begin
      o_idx_val <= 1'b0;
      case (state)
        U_IDLE: begin
          if (i_start) begin
            o_rd_addr <= '0;
            state     <= U_LOAD0;
          end
        end
        U_LOAD0: begin
          o_rd_addr <= next_addr;
          state     <= U_LOAD1;
        end
        U_LOAD1: begin
          o_rd_addr <= next_addr;
          state     <= U_LOAD2;
        end
        U_LOAD2: begin
          pos     <= '0;
          idx_cnt <= '0;
          state   <= U_RUN;
        end
        U_RUN: begin
          if (refill) begin
            o_rd_addr <= next_addr;
            pos       <= pos - WORD_POS;
          end else begin
            o_idx_val <= 1'b1;
            pos       <= pos + STEP;
            idx_cnt   <= idx_cnt + 1'b1;
            if (idx_cnt == LAST_IDX) begin
              state <= U_IDLE;
            end
          end
        end
        default: state <= U_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    case (state)
      U_LOAD1: win_lo <= i_rd_data;
      U_LOAD2: win_hi <= i_rd_data;
      U_RUN: begin
        if (refill) begin
          win_lo <= win_hi;
          win_hi <= i_rd_data;
        end
      end
      default: ;
    endcase
    o_idx.idx   <= IDX_W'(cur_idx);
    o_idx.first <= (idx_cnt == '0);
    o_idx.last  <= (idx_cnt == LAST_IDX);
  end

endmodule

`default_nettype wire

//--- verilog/order_check.sv
// Tree-ordering check on the index list.
// At every level h the first index of a block of 2^h entries must be
// strictly below the first index of the block's second half.
// Result comes with o_done one cycle after the last beat.
`timescale 1ns/1ps
`default_nettype none

module order_check #(
  parameter int SOL_LIST_LEN = equihash_pkg::DEF_SOL_LIST_LEN
) (
  input  wire logic                    i_clk,
  input  wire logic                    i_rst,
  input  wire logic                    i_idx_val,
  input  wire equihash_pkg::idx_beat_t i_idx,
  output logic                         o_done,
  output logic                         o_wrong
);

  localparam int LEVELS = $clog2(SOL_LIST_LEN);
  localparam int IDX_W  = equihash_pkg::MAX_SOL_BITS;

  logic [LEVELS-1:0] cnt;
  logic [LEVELS-1:0] cnt_cur;
  logic [IDX_W-1:0]  opener [1:LEVELS];
  logic              wrong_acc;
  logic              wrong_cur;
  logic              bad_now;

  // Position of n inside its block of 2^h entries
  function automatic logic [LEVELS-1:0] in_block(input logic [LEVELS-1:0] n, input int h);
    return n & LEVELS'((1 << h) - 1);
  endfunction

  assign cnt_cur = i_idx.first ? '0 : cnt;

  always_comb begin
    bad_now = 1'b0;
    for (int h = 1; h <= LEVELS; h++) begin
      // Beat opens the second half of a level-h block
      if (in_block(cnt_cur, h) == LEVELS'(1 << (h - 1)) && opener[h] >= i_idx.idx) begin
        bad_now = 1'b1;
      end
    end
  end

  assign wrong_cur = (i_idx.first ? 1'b0 : wrong_acc) | bad_now;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cnt       <= '0;
      wrong_acc <= 1'b0;
      o_done    <= 1'b0;
    end else begin
      o_done <= i_idx_val && i_idx.last;
      if (i_idx_val) begin
        cnt       <= cnt_cur + 1'b1;
        wrong_acc <= wrong_cur;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_idx_val) begin
      for (int h = 1; h <= LEVELS; h++) begin
        if (in_block(cnt_cur, h) == '0) begin
          opener[h] <= i_idx.idx;
        end
      end
      o_wrong <= wrong_cur;
    end
  end

endmodule

`default_nettype wire

//--- verilog/dup_check.sv
// Duplicate-index check.
// Every new index is compared in parallel with all earlier indices of
// the same solution. Any match sets a flag that holds to the end.
// Result comes with o_done one cycle after the last beat.
`timescale 1ns/1ps
`default_nettype none

module dup_check #(
  parameter int SOL_BITS     = equihash_pkg::DEF_SOL_BITS,
  parameter int SOL_LIST_LEN = equihash_pkg::DEF_SOL_LIST_LEN
) (
  input  wire logic                    i_clk,
  input  wire logic                    i_rst,
  input  wire logic                    i_idx_val,
  input  wire equihash_pkg::idx_beat_t i_idx,
  output logic                         o_done,
  output logic                         o_dup
);

  localparam int CNT_W = $clog2(SOL_LIST_LEN + 1);
  localparam int SEL_W = $clog2(SOL_LIST_LEN);

  logic [SOL_BITS-1:0] seen [SOL_LIST_LEN];
  logic [CNT_W-1:0]    cnt;
  logic [CNT_W-1:0]    cnt_cur;
  logic [SOL_BITS-1:0] new_idx;
  logic                hit;
  logic                dup_acc;
  logic                dup_cur;

  assign new_idx = i_idx.idx[SOL_BITS-1:0];
  assign cnt_cur = i_idx.first ? '0 : cnt;

  // Only entries below the valid count belong to this solution
  always_comb begin
    hit = 1'b0;
    for (int j = 0; j < SOL_LIST_LEN; j++) begin
      if (CNT_W'(j) < cnt_cur && seen[j] == new_idx) begin
        hit = 1'b1;
      end
    end
  end

  assign dup_cur = (i_idx.first ? 1'b0 : dup_acc) | hit;

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      cnt     <= '0;
      dup_acc <= 1'b0;
      o_done  <= 1'b0;
    end else begin
      o_done <= i_idx_val && i_idx.last;
      if (i_idx_val) begin
        cnt     <= cnt_cur + 1'b1;
        dup_acc <= dup_cur;
      end
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_idx_val) begin
      seen[cnt_cur[SEL_W-1:0]] <= new_idx;
      o_dup                    <= dup_cur;
    end
  end

endmodule

`default_nettype wire

//--- verilog/verif_result.sv
// Result collector.
// Waits for both checkers, or for a length error from the store, then
// pulses o_mask_val with the mask and frees the store for the next one.
`timescale 1ns/1ps
`default_nettype none

module verif_result (
  input  wire logic                  i_clk,
  input  wire logic                  i_rst,
  input  wire logic                  i_sol_end,
  input  wire logic                  i_len_err,
  input  wire logic                  i_order_done,
  input  wire logic                  i_order_wrong,
  input  wire logic                  i_dup_done,
  input  wire logic                  i_dup,
  output equihash_pkg::verif_mask_t  o_mask,
  output logic                       o_mask_val,
  output logic                       o_release
);

  logic ord_l;
  logic ord_wrong_l;
  logic dup_l;
  logic dup_fnd_l;
  logic both_in;

  // A done arriving this cycle counts as already seen
  assign both_in = (ord_l | i_order_done) & (dup_l | i_dup_done);

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      o_mask      <= '0;
      o_mask_val  <= 1'b0;
      ord_l       <= 1'b0;
      ord_wrong_l <= 1'b0;
      dup_l       <= 1'b0;
      dup_fnd_l   <= 1'b0;
    end else begin
      o_mask_val <= 1'b0;
      if (i_sol_end && i_len_err) begin
        // No checks run on a bad length
        o_mask_val <= 1'b1;
        o_mask     <= '{dup_fnd: 1'b0, bad_idx_order: 1'b0, len_err: 1'b1};
      end else if (both_in) begin
        o_mask_val           <= 1'b1;
        o_mask.dup_fnd       <= dup_fnd_l | (i_dup_done & i_dup);
        o_mask.bad_idx_order <= ord_wrong_l | (i_order_done & i_order_wrong);
        o_mask.len_err       <= 1'b0;
        ord_l                <= 1'b0;
        ord_wrong_l          <= 1'b0;
        dup_l                <= 1'b0;
        dup_fnd_l            <= 1'b0;
      end else begin
        if (i_order_done) begin
          ord_l       <= 1'b1;
          ord_wrong_l <= i_order_wrong;
        end
        if (i_dup_done) begin
          dup_l     <= 1'b1;
          dup_fnd_l <= i_dup;
        end
      end
    end
  end

  assign o_release = o_mask_val;

endmodule

`default_nettype wire

//--- verilog/equihash_verif_top.sv
// Top level of the Equihash index-list checker.
// Takes the compressed solution as a valid/ready word stream and reports
// a three-bit failure mask with a one-cycle valid pulse.
`timescale 1ns/1ps
`default_nettype none

module equihash_verif_top #(
  parameter int DAT_BYTS     = equihash_pkg::DEF_DAT_BYTS,
  parameter int SOL_BITS     = equihash_pkg::DEF_SOL_BITS,
  parameter int SOL_LIST_LEN = equihash_pkg::DEF_SOL_LIST_LEN
) (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst,
  input  wire logic                   i_valid,
  input  wire equihash_pkg::in_beat_t i_beat,
  output logic                        o_ready,
  output equihash_pkg::verif_mask_t   o_mask,
  output logic                        o_mask_val
);

  // Read bus widths, same sizing as the store and the unpacker
  localparam int DAT_BITS  = DAT_BYTS * 8;
  localparam int SOL_WORDS = (SOL_BITS * SOL_LIST_LEN + DAT_BITS - 1) / DAT_BITS;
  localparam int ADDR_W    = (SOL_WORDS > 1) ? $clog2(SOL_WORDS) : 1;

  logic [ADDR_W-1:0]       rd_addr;
  logic [DAT_BITS-1:0]     rd_data;
  logic                    start;
  logic                    sol_end;
  logic                    len_err;
  logic                    release_sol;
  logic                    idx_val;
  equihash_pkg::idx_beat_t idx;
  logic                    order_done;
  logic                    order_wrong;
  logic                    dup_done;
  logic                    dup;

  sol_store #(
    .DAT_BYTS     (DAT_BYTS),
    .SOL_BITS     (SOL_BITS),
    .SOL_LIST_LEN (SOL_LIST_LEN)
  ) u_sol_store (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_valid   (i_valid),
    .i_beat    (i_beat),
    .i_release (release_sol),
    .i_rd_addr (rd_addr),
    .o_ready   (o_ready),
    .o_rd_data (rd_data),
    .o_start   (start),
    .o_sol_end (sol_end),
    .o_len_err (len_err)
  );

  index_unpacker #(
    .DAT_BYTS     (DAT_BYTS),
    .SOL_BITS     (SOL_BITS),
    .SOL_LIST_LEN (SOL_LIST_LEN)
  ) u_index_unpacker (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_start   (start),
    .i_rd_data (rd_data),
    .o_rd_addr (rd_addr),
    .o_idx_val (idx_val),
    .o_idx     (idx)
  );

  order_check #(
    .SOL_LIST_LEN (SOL_LIST_LEN)
  ) u_order_check (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_idx_val (idx_val),
    .i_idx     (idx),
    .o_done    (order_done),
    .o_wrong   (order_wrong)
  );

  dup_check #(
    .SOL_BITS     (SOL_BITS),
    .SOL_LIST_LEN (SOL_LIST_LEN)
  ) u_dup_check (
    .i_clk     (i_clk),
    .i_rst     (i_rst),
    .i_idx_val (idx_val),
    .i_idx     (idx),
    .o_done    (dup_done),
    .o_dup     (dup)
  );

  verif_result u_verif_result (
    .i_clk         (i_clk),
    .i_rst         (i_rst),
    .i_sol_end     (sol_end),
    .i_len_err     (len_err),
    .i_order_done  (order_done),
    .i_order_wrong (order_wrong),
    .i_dup_done    (dup_done),
    .i_dup         (dup),
    .o_mask        (o_mask),
    .o_mask_val    (o_mask_val),
    .o_release     (release_sol)
  );

endmodule

`default_nettype wire

//--- tests/tb_checker.sv
// Scoreboard for the index-list checker testbench.
// Rebuilds every accepted solution from the input handshake, predicts the
// mask with a reference model of the length, duplicate and ordering rules
// and compares it with the DUT mask. Also watches the input back-pressure.
`timescale 1ns/1ps
`default_nettype none

module tb_checker #(
  parameter int DAT_BYTS     = equihash_pkg::DEF_DAT_BYTS,
  parameter int SOL_BITS     = equihash_pkg::DEF_SOL_BITS,
  parameter int SOL_LIST_LEN = equihash_pkg::DEF_SOL_LIST_LEN
) (
  input  wire logic                      i_clk,
  input  wire logic                      i_rst,
  input  wire logic                      i_valid,
  input  wire equihash_pkg::in_beat_t    i_beat,
  input  wire logic                      i_ready,
  input  wire equihash_pkg::verif_mask_t i_mask,
  input  wire logic                      i_mask_val,
  output int                             o_n_tests,
  output int                             o_n_errors
);

  localparam int DAT_BITS  = DAT_BYTS * 8;
  localparam int SOL_WORDS = (SOL_BITS * SOL_LIST_LEN + DAT_BITS - 1) / DAT_BITS;

  logic [DAT_BITS-1:0]       rx_words [SOL_WORDS];
  int                        rx_cnt;
  logic                      in_flight;
  logic                      ready_due;
  equihash_pkg::verif_mask_t exp_q [$];
  equihash_pkg::verif_mask_t exp_mask;

  // Bit k of the stream with byte 0 first and MSB first inside a byte
  function automatic logic stream_bit(input int k);
    return rx_words[k / DAT_BITS][((k % DAT_BITS) / 8) * 8 + 7 - k % 8];
  endfunction

  function automatic equihash_pkg::verif_mask_t expected_mask(input int n_words);
    equihash_pkg::verif_mask_t m;
    logic [SOL_BITS-1:0]       idx [SOL_LIST_LEN];
    m = '0;
    if (n_words != SOL_WORDS) begin
      m.len_err = 1'b1;
      return m;
    end
    for (int i = 0; i < SOL_LIST_LEN; i++) begin
      for (int b = 0; b < SOL_BITS; b++) begin
        idx[i][SOL_BITS-1-b] = stream_bit(i * SOL_BITS + b);
      end
    end
    for (int i = 1; i < SOL_LIST_LEN; i++) begin
      for (int j = 0; j < i; j++) begin
        if (idx[i] == idx[j]) m.dup_fnd = 1'b1;
      end
    end
    // Each block's first index must be below the first of its second half
    for (int half = 1; half < SOL_LIST_LEN; half = half * 2) begin
      for (int s = 0; s < SOL_LIST_LEN; s = s + 2 * half) begin
        if (idx[s] >= idx[s + half]) m.bad_idx_order = 1'b1;
      end
    end
    return m;
  endfunction

  always @(posedge i_clk) begin
    if (i_rst) begin
      rx_cnt     = 0;
      in_flight  = 1'b0;
      ready_due  = 1'b0;
      o_n_tests  = 0;
      o_n_errors = 0;
      exp_q.delete();
    end else begin
      if (ready_due && !i_ready) begin
        $display("** Error at %0t: o_ready not back after the mask", $time);
        o_n_errors = o_n_errors + 1;
      end
      ready_due = 1'b0;
      if (in_flight && i_ready) begin
        $display("** Error at %0t: o_ready high while a solution is in flight", $time);
        o_n_errors = o_n_errors + 1;
      end
      if (i_valid && i_ready) begin
        if (rx_cnt < SOL_WORDS) rx_words[rx_cnt] = i_beat.dat;
        rx_cnt = rx_cnt + 1;
        if (i_beat.eop) begin
          exp_q.push_back(expected_mask(rx_cnt));
          rx_cnt    = 0;
          in_flight = 1'b1;
        end
      end
      if (i_mask_val) begin
        if (exp_q.size() == 0) begin
          $display("A result came out at %0t with no solution sent", $time);
          o_n_errors = o_n_errors + 1;
        end else begin
          exp_mask  = exp_q.pop_front();
          o_n_tests = o_n_tests + 1;
          if (i_mask !== exp_mask) begin
            $display("** Error at %0t: test %0d mask %b, expected %b",
                     $time, o_n_tests, i_mask, exp_mask);
            o_n_errors = o_n_errors + 1;
          end
          $display("test %0d finished at %0t, mask %b", o_n_tests, $time, i_mask);
        end
        in_flight = 1'b0;
        ready_due = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- tests/tb_equihash_verif.sv
// Testbench top for the Equihash index-list checker.
// Packs index lists into input words, sends them with random gaps on the
// falling clock edge and leaves all checking to the scoreboard module.
// A watchdog bounds the run by the number of solutions sent.
`timescale 1ns/1ps
`default_nettype none

module tb_equihash_verif;

  localparam int DAT_BYTS        = equihash_pkg::DEF_DAT_BYTS;
  localparam int SOL_BITS        = equihash_pkg::DEF_SOL_BITS;
  localparam int SOL_LIST_LEN    = equihash_pkg::DEF_SOL_LIST_LEN;
  localparam int DAT_BITS        = DAT_BYTS * 8;
  localparam int SOL_WORDS       = (SOL_BITS * SOL_LIST_LEN + DAT_BITS - 1) / DAT_BITS;
  localparam int N_RANDOM        = 50;
  localparam int N_SOLS          = 5 + N_RANDOM;
  localparam int WATCHDOG_CYCLES = 4 + N_SOLS * 40 * SOL_WORDS;

  logic                      i_clk = 1'b0;
  logic                      i_rst;
  logic                      i_valid;
  equihash_pkg::in_beat_t    i_beat;
  logic                      o_ready;
  equihash_pkg::verif_mask_t o_mask;
  logic                      o_mask_val;
  int                        n_tests;
  int                        n_errors;
  int                        val;
  logic [31:0]               rnd = 32'h3e9d;
  logic [SOL_BITS-1:0]       idx_list [SOL_LIST_LEN];
  logic [DAT_BITS-1:0]       words [SOL_WORDS + 2];

  always #4 i_clk = ~i_clk;

  equihash_verif_top #(
    .DAT_BYTS     (DAT_BYTS),
    .SOL_BITS     (SOL_BITS),
    .SOL_LIST_LEN (SOL_LIST_LEN)
  ) DUT (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_valid    (i_valid),
    .i_beat     (i_beat),
    .o_ready    (o_ready),
    .o_mask     (o_mask),
    .o_mask_val (o_mask_val)
  );

  tb_checker #(
    .DAT_BYTS     (DAT_BYTS),
    .SOL_BITS     (SOL_BITS),
    .SOL_LIST_LEN (SOL_LIST_LEN)
  ) u_checker (
    .i_clk      (i_clk),
    .i_rst      (i_rst),
    .i_valid    (i_valid),
    .i_beat     (i_beat),
    .i_ready    (o_ready),
    .i_mask     (o_mask),
    .i_mask_val (o_mask_val),
    .o_n_tests  (n_tests),
    .o_n_errors (n_errors)
  );

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Strictly rising and distinct so every ordering rule holds
  function automatic void ordered_list();
    for (int i = 0; i < SOL_LIST_LEN; i++) begin
      idx_list[i] = SOL_BITS'(3 * i + 1);
    end
  endfunction

  // Stream order is byte 0 first and MSB first with the index MSB leading
  function automatic void pack_list();
    int k;
    for (int w = 0; w < SOL_WORDS; w++) words[w] = '0;
    for (int i = 0; i < SOL_LIST_LEN; i++) begin
      for (int b = 0; b < SOL_BITS; b++) begin
        k = i * SOL_BITS + b;
        words[k / DAT_BITS][((k % DAT_BITS) / 8) * 8 + 7 - k % 8] = idx_list[i][SOL_BITS-1-b];
      end
    end
  endfunction

  // Called on a falling edge while o_ready only moves on the rising edge
  task automatic send_solution(input int n_words);
    for (int w = 0; w < n_words; w++) begin
      rnd = lcg_next(rnd);
      repeat (rnd[17:16]) @(negedge i_clk);
      i_valid     = 1'b1;
      i_beat.dat  = words[w];
      i_beat.eop  = (w == n_words - 1);
      while (!o_ready) @(negedge i_clk);
      @(negedge i_clk);
      i_valid = 1'b0;
    end
  endtask

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge i_clk);
    $display("Timeout: only %0d of %0d results arrived", n_tests, N_SOLS);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin
    i_rst   = 1'b1;
    i_valid = 1'b0;
    i_beat  = '0;
    repeat (4) @(negedge i_clk);
    i_rst = 1'b0;

    ordered_list();
    pack_list();
    send_solution(SOL_WORDS);

    // Repeat one index while ordering still holds
    idx_list[1] = idx_list[2];
    pack_list();
    send_solution(SOL_WORDS);

    // Swapped pair at level 1
    ordered_list();
    val         = int'(idx_list[4]);
    idx_list[4] = idx_list[5];
    idx_list[5] = SOL_BITS'(val);
    pack_list();
    send_solution(SOL_WORDS);

    ordered_list();
    pack_list();
    send_solution(SOL_WORDS - 1);
    words[SOL_WORDS]     = {lcg_next(rnd), lcg_next(rnd + 32'd1)};
    words[SOL_WORDS + 1] = {lcg_next(rnd + 32'd2), lcg_next(rnd + 32'd3)};
    send_solution(SOL_WORDS + 2);

    // Odd runs are rising lists with random steps so some of them pass
    for (int t = 0; t < N_RANDOM; t++) begin
      val = 0;
      for (int i = 0; i < SOL_LIST_LEN; i++) begin
        rnd = lcg_next(rnd);
        if (t % 2 == 1) begin
          val         = val + 1 + int'(rnd[20:16]) % 30;
          idx_list[i] = SOL_BITS'(val);
        end else begin
          idx_list[i] = rnd[SOL_BITS+15:16];
        end
      end
      pack_list();
      send_solution(SOL_WORDS);
    end

    while (n_tests < N_SOLS) @(negedge i_clk);
    repeat (4) @(negedge i_clk);
    $display("%0d of %0d tests checked, %0d errors", n_tests, N_SOLS, n_errors);
    if (n_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
verilog/equihash_pkg.sv
verilog/sol_store.sv
verilog/index_unpacker.sv
verilog/order_check.sv
verilog/dup_check.sv
verilog/verif_result.sv
verilog/equihash_verif_top.sv
tests/tb_checker.sv
tests/tb_equihash_verif.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then look for the failure message in the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_equihash_verif \
  -o sim_tb > build.log 2>&1 \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || { cat build.log; echo "Build or run failed"; exit 1; }

cat sim.log

grep -q "ERRORS FOUND" sim.log \
  && { echo "Simulation failed"; exit 1; } \
  || echo "Simulation passed"
